//--- Makefile
SIM      = verilator
TOP      = tb_fuel_gauge
FILELIST = project.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAG = --lint-only --timing --assert --timescale 1ns/1ps -Wall
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(SIM) $(LINTFLAG) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/gauge_testdata.mem
// nominal status config busy_rd fullcap repsoc repcap age temp passes
//   exp_designcap exp_config exp_status delta, one test per line, hex
// por set, two busy MODELCFG reads, single pass
1388 0002 2210 0002 1300 3200 0f00 6400 1680 0001 2710 a210 0000 0000
// por set with other status bits, config bit 15 already set, capacity wraps
9c40 8083 8211 0000 2580 4d00 1c80 5a00 1720 0001 3880 8211 8081 0000
// por clear, no configuration
0bb8 0080 0000 0000 0bb8 2800 04b0 6200 1900 0001 0000 0000 0000 0000
// por clear, cyclic mode over three passes
07d0 0000 0000 0000 07d0 6400 07d0 6400 1a00 0003 0000 0000 0000 0011
// por set, five busy reads, cyclic mode over two passes
ffff 0002 0000 0005 1f00 3000 0c00 5f00 1800 0002 fffe 8000 0000 0101

//--- bench/i2c_gauge_model.sv
// behavioral byte-level I2C controller plus the fuel-gauge chip's register file
// serves one word per wen/ren level, low byte first, and logs every write
// a load pulse copies one test record from the data file into the registers
`timescale 1ns/1ps
`default_nettype none

module i2c_gauge_model import gauge_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        load,
    input  wire logic [7:0]  test_idx,
    input  wire gauge_addr_t word_addr,
    input  wire logic        wen,
    input  wire logic        ren,
    input  wire logic [7:0]  wdata,
    output logic             wvalid,
    output logic             rvalid,
    output logic [7:0]       rdata,
    output logic             ready,
    output logic             done
);

    localparam int rec_words = 14;

    gauge_word_t tdata [0:127];
    gauge_word_t regs [0:255];
    gauge_addr_t wr_addr_log [0:15];
    gauge_word_t wr_word_log [0:15];
    int          n_writes;
    int          mcfg_reads;
    int          mcfg_at_status;  // MODELCFG reads seen when STATUS got written
    int          busy_reads;
    gauge_word_t delta;           // added to the measurement registers per pass
    integer      seed;
    logic        load_q;

    // control inputs sampled on the edge, bus pins driven 2 ns later
    task automatic tick();
        @(posedge clk);
        load_q = load;
        #2;
    endtask

    task automatic load_record();
        int b;
        b = int'(test_idx) * rec_words;
        regs[status_addr]     = tdata[b+1];
        regs[config_addr]     = tdata[b+2];
        regs[modelcfg_addr]   = '0;
        regs[fullcaprep_addr] = tdata[b+4];
        regs[repsoc_addr]     = tdata[b+5];
        regs[repcap_addr]     = tdata[b+6];
        regs[age_addr]        = tdata[b+7];
        regs[temp_addr]       = tdata[b+8];
        busy_reads     = int'(tdata[b+3]);
        delta          = tdata[b+13];
        n_writes       = 0;
        mcfg_reads     = 0;
        mcfg_at_status = -1;
    endtask

    task automatic serve();
        gauge_addr_t a;
        gauge_word_t w;
        ready = 1'b0;
        a = word_addr;
        repeat ({$random(seed)} % 4) tick();  // controller latency
        if (wen) begin
            for (int i = 0; i < 2; i++) begin
                wvalid = 1'b1;
                w[8*i +: 8] = wdata;
                tick();
                wvalid = 1'b0;
                tick();
            end
            regs[a] = w;
            if (a == status_addr)
                mcfg_at_status = mcfg_reads;
            if (n_writes < 16) begin
                wr_addr_log[n_writes] = a;
                wr_word_log[n_writes] = w;
            end
            n_writes++;
        end else begin
            w = regs[a];
            if (a == modelcfg_addr) begin
                w[refresh_bit] = (mcfg_reads < busy_reads);  // busy for N reads
                mcfg_reads++;
            end
            for (int i = 0; i < 2; i++) begin
                rvalid = 1'b1;
                rdata  = w[8*i +: 8];
                tick();
                rvalid = 1'b0;
                tick();
            end
            // temp is the last read of a pass, so the next pass sees new values
            if (a == temp_addr) begin
                regs[fullcaprep_addr] += delta;
                regs[repsoc_addr]     += delta;
                regs[repcap_addr]     += delta;
                regs[age_addr]        += delta;
                regs[temp_addr]       += delta;
            end
        end
        done = 1'b1;
        tick();
        done  = 1'b0;
        ready = 1'b1;
    endtask

    initial begin
        seed   = 32'hac8c8d01;
        ready  = 1'b0;
        wvalid = 1'b0;
        rvalid = 1'b0;
        rdata  = '0;
        done   = 1'b0;
        load_q = 1'b0;
        $readmemh("bench/gauge_testdata.mem", tdata);
        load_record();
        forever begin
            tick();
            if (load_q)
                load_record();
            else if (rst_n && (wen || ren))
                serve();
            else
                ready = rst_n;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_fuel_gauge.sv
// testbench for the fuel-gauge driver
// each record of the test data file is one test, run against the controller model
// checks configuration writes, the MODELCFG poll and the published results
`timescale 1ns/1ps
`default_nettype none

module tb_fuel_gauge import gauge_pkg::*; ();

    localparam int rec_words  = 14;    // words per test record
    localparam int n_tests    = 5;
    localparam int wait_limit = 5000;  // clocks per wait loop
    localparam int quiet_time = 300;   // longer than one measurement pass

    logic        clk;
    logic        rst_n;
    logic        measure_start;
    logic        measure_cycle;
    gauge_word_t nominal_cap;
    logic        measure_done;
    gauge_addr_t word_addr;
    logic        wen, ren, wvalid, rvalid, ready, done;
    logic [7:0]  wdata, rdata;
    gauge_word_t fullcap, repsoc, repcap, age, thrmtemp;
    logic        load;
    logic [7:0]  test_idx;

    gauge_word_t tdata [0:127];
    int          errors;
    int          bad_tests;

    fuel_gauge_top uut (.*);

    i2c_gauge_model model (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    // ============================================================
    // compare tasks
    task automatic check_word(input string name, input gauge_word_t exp, input gauge_word_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input gauge_addr_t exp, input gauge_addr_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // waits for the next measure_done while the results hold still
    task automatic wait_pulse(input string name, output bit seen);
        logic [79:0] snap;
        seen = 1'b0;
        snap = {fullcap, repsoc, repcap, age, thrmtemp};
        for (int n = 0; n < wait_limit && !seen; n++) begin
            tick();
            if (measure_done) begin
                seen = 1'b1;
            end else if ({fullcap, repsoc, repcap, age, thrmtemp} !== snap) begin
                $display("%s: results changed without measure_done", name);
                errors++;
                snap = {fullcap, repsoc, repcap, age, thrmtemp};
            end
        end
        if (!seen) begin
            $display("%s: timed out waiting for measure_done", name);
            errors++;
        end
    endtask

    // ============================================================
    // one test record
    task automatic run_test(input int t);
        int          b;
        int          passes;
        int          err0;
        bit          seen;
        string       name;
        gauge_word_t step;
        gauge_addr_t exp_a [4];
        gauge_word_t exp_w [4];
        b      = t * rec_words;
        passes = int'(tdata[b+9]);
        err0   = errors;
        seen   = 1'b1;
        name   = $sformatf("test%0d", t);
        test_idx = 8'(t);
        load     = 1'b1;
        tick();
        load          = 1'b0;
        nominal_cap   = tdata[b];
        measure_cycle = (passes > 1);
        measure_start = 1'b1;
        tick();
        measure_start = 1'b0;
        for (int k = 0; k < passes && seen; k++) begin
            wait_pulse(name, seen);
            if (k == passes - 2)
                measure_cycle = 1'b0;  // one more pass after this
            step = gauge_word_t'(k) * tdata[b+13];
            check_word($sformatf("%s pass%0d fullcap", name, k), tdata[b+4] + step, fullcap);
            check_word($sformatf("%s pass%0d repsoc", name, k), tdata[b+5] + step, repsoc);
            check_word($sformatf("%s pass%0d repcap", name, k), tdata[b+6] + step, repcap);
            check_word($sformatf("%s pass%0d age", name, k), tdata[b+7] + step, age);
            check_word($sformatf("%s pass%0d temp", name, k), tdata[b+8] + step, thrmtemp);
        end
        for (int n = 0; n < quiet_time && seen; n++) begin
            tick();
            if (measure_done) begin
                $display("%s: measure_done pulsed after the last pass", name);
                errors++;
            end
        end
        if (tdata[b+1][por_bit]) begin
            exp_a = '{designcap_addr, config_addr, modelcfg_addr, status_addr};
            exp_w = '{tdata[b+10], tdata[b+11], modelcfg_word, tdata[b+12]};
            check_count($sformatf("%s write count", name), 4, model.n_writes);
            for (int i = 0; i < 4; i++) begin
                check_addr($sformatf("%s write%0d addr", name, i), exp_a[i],
                           model.wr_addr_log[i]);
                check_word($sformatf("%s write%0d data", name, i), exp_w[i],
                           model.wr_word_log[i]);
            end
            check_count($sformatf("%s modelcfg reads", name), int'(tdata[b+3]) + 1,
                        model.mcfg_at_status);
        end else begin
            check_count($sformatf("%s write count", name), 0, model.n_writes);
        end
        if (errors != err0)
            bad_tests++;
        $display("%s done, %0d errors", name, errors - err0);
    endtask

    initial begin
        rst_n         = 1'b0;
        measure_start = 1'b0;
        measure_cycle = 1'b0;
        nominal_cap   = '0;
        load          = 1'b0;
        test_idx      = '0;
        errors        = 0;
        bad_tests     = 0;
        $readmemh("bench/gauge_testdata.mem", tdata);
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        tick();
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        $display("tests %0d, failed tests %0d, failed checks %0d", n_tests, bad_tests, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/fuel_gauge_top.sv
// fuel-gauge driver top level
// connects to an external byte-level I2C controller through plain strobes
// chip at 8-bit slave address 0x6C, which the controller holds fixed
`timescale 1ns/1ps
`default_nettype none

module fuel_gauge_top import gauge_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        measure_start,
    input  wire logic        measure_cycle,  // 1 repeats passes
    input  wire gauge_word_t nominal_cap,    // mAh
    output logic             measure_done,
    // I2C controller side
    output gauge_addr_t      word_addr,
    output logic             wen,
    output logic [7:0]       wdata,
    input  wire logic        wvalid,
    output logic             ren,
    input  wire logic [7:0]  rdata,
    input  wire logic        rvalid,
    input  wire logic        ready,
    input  wire logic        done,
    // results
    output gauge_word_t      fullcap,
    output gauge_word_t      repsoc,
    output gauge_word_t      repcap,
    output gauge_word_t      age,
    output gauge_word_t      thrmtemp
);

    logic      capture;
    logic      publish;
    meas_sel_t meas_sel;

    gauge_xfer_if xfer_bus ();

    gauge_sequencer u_seq (
        .clk, .rst_n, .measure_start, .measure_cycle, .nominal_cap,
        .xfer(xfer_bus.seq), .capture, .meas_sel, .publish, .measure_done
    );

    word_transfer u_xfer (
        .clk, .rst_n, .xfer(xfer_bus.xfer), .word_addr, .wen, .ren, .wdata,
        .wvalid, .rvalid, .rdata, .ready, .done
    );

    result_bank u_bank (
        .clk, .rst_n, .capture, .meas_sel, .publish, .rd_word(xfer_bus.rd_word),
        .fullcap, .repsoc, .repcap, .age, .thrmtemp
    );

endmodule

`default_nettype wire

//--- hdl/gauge_pkg.sv
// shared definitions for the fuel-gauge driver
// register map, fixed write words, bit positions and the design's enum types
// import with gauge_pkg::* in the module header
`default_nettype none

package gauge_pkg;

    typedef logic [15:0] gauge_word_t;  // one chip register
    typedef logic [7:0]  gauge_addr_t;  // register address

    // ============================================================
    // chip register map
    localparam gauge_addr_t status_addr     = 8'h00;
    localparam gauge_addr_t config_addr     = 8'h1d;
    localparam gauge_addr_t designcap_addr  = 8'h18;
    localparam gauge_addr_t modelcfg_addr   = 8'hdb;
    localparam gauge_addr_t fullcaprep_addr = 8'h10;
    localparam gauge_addr_t repsoc_addr     = 8'h06;
    localparam gauge_addr_t repcap_addr     = 8'h05;
    localparam gauge_addr_t age_addr        = 8'h07;
    localparam gauge_addr_t temp_addr       = 8'h08;

    localparam gauge_word_t modelcfg_word = 16'h8400;  // refresh plus model select

    localparam int por_bit        = 1;   // STATUS power-on reset
    localparam int refresh_bit    = 15;  // MODELCFG busy while model loads
    localparam int config_set_bit = 15;

    // 1 us at 100 MHz
    localparam int settle_cycles = 100;
    localparam int settle_w      = $clog2(settle_cycles);

    // ============================================================
    // enums
    typedef enum logic {op_read, op_write} xfer_op_t;

    typedef enum logic [2:0] {
        meas_fullcap, meas_repsoc, meas_repcap, meas_age, meas_temp
    } meas_sel_t;

    typedef enum logic [4:0] {
        st_idle, st_status_s, st_config_r, st_designcap, st_config_w,
        st_modelcfg_w, st_modelcfg_r, st_status_r, st_status_w, st_settle,
        st_status_v, st_fullcap, st_repsoc, st_repcap, st_age, st_temp, st_publish
    } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/gauge_sequencer.sv
// control FSM of the fuel-gauge driver
// status check, optional chip configuration, settle delay and measurement loop
// issues one register transfer per state and advances on finish
`timescale 1ns/1ps
`default_nettype none

module gauge_sequencer import gauge_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        measure_start,
    input  wire logic        measure_cycle,
    input  wire gauge_word_t nominal_cap,
    gauge_xfer_if.seq        xfer,
    output logic             capture,
    output meas_sel_t        meas_sel,
    output logic             publish,
    output logic             measure_done
);

    seq_state_t           state, next_state;
    logic [settle_w-1:0]  settle_cnt;
    gauge_word_t          config_word;  // saved for read-modify-write
    gauge_word_t          status_word;
    gauge_word_t          cap_x2;

    function automatic logic is_xfer(input seq_state_t s);
        return !(s inside {st_idle, st_settle, st_publish});
    endfunction

    // ============================================================
    // next state
    always_comb begin
        next_state = state;
        case (state)
            st_idle:       if (measure_start) next_state = st_status_s;
            st_status_s:   if (xfer.finish)
                               next_state = xfer.rd_word[por_bit] ? st_config_r : st_fullcap;
            st_config_r:   if (xfer.finish) next_state = st_designcap;
            st_designcap:  if (xfer.finish) next_state = st_config_w;
            st_config_w:   if (xfer.finish) next_state = st_modelcfg_w;
            st_modelcfg_w: if (xfer.finish) next_state = st_modelcfg_r;
            st_modelcfg_r: if (xfer.finish && !xfer.rd_word[refresh_bit])
                               next_state = st_status_r;  // else poll again
            st_status_r:   if (xfer.finish) next_state = st_status_w;
            st_status_w:   if (xfer.finish) next_state = st_settle;
            st_settle:     if (settle_cnt == settle_w'(settle_cycles - 1))
                               next_state = st_status_v;
            st_status_v:   if (xfer.finish)
                               next_state = xfer.rd_word[por_bit] ? st_status_s : st_fullcap;
            st_fullcap:    if (xfer.finish) next_state = st_repsoc;
            st_repsoc:     if (xfer.finish) next_state = st_repcap;
            st_repcap:     if (xfer.finish) next_state = st_age;
            st_age:        if (xfer.finish) next_state = st_temp;
            st_temp:       if (xfer.finish) next_state = st_publish;
            st_publish:    next_state = measure_cycle ? st_fullcap : st_idle;
            default:       next_state = st_idle;
        endcase
    end

    // start fires on entry to a transfer state, or again on a repeated poll
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            xfer.start   <= 1'b0;
            measure_done <= 1'b0;
            settle_cnt   <= '0;
        end else begin
            state        <= next_state;
            xfer.start   <= is_xfer(next_state) && (next_state != state || xfer.finish);
            measure_done <= publish;  // same edge as the bank loads outputs
            settle_cnt   <= (state == st_settle) ? settle_cnt + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && measure_start)
            cap_x2 <= nominal_cap << 1;  // chip counts in 0.5 mAh units
        if (state == st_config_r && xfer.finish)
            config_word <= xfer.rd_word;
        if (state == st_status_r && xfer.finish)
            status_word <= xfer.rd_word;
    end

    // ============================================================
    // transfer request
    always_comb begin
        xfer.op      = op_read;
        xfer.wr_word = '0;
        case (state)
            st_designcap: begin
                xfer.op      = op_write;
                xfer.wr_word = cap_x2;
            end
            st_config_w: begin
                xfer.op      = op_write;
                xfer.wr_word = config_word | (16'h1 << config_set_bit);
            end
            st_modelcfg_w: begin
                xfer.op      = op_write;
                xfer.wr_word = modelcfg_word;
            end
            st_status_w: begin
                xfer.op      = op_write;
                xfer.wr_word = status_word & ~(16'h1 << por_bit);  // clear POR
            end
            default: ;
        endcase
    end

    always_comb begin
        case (state)
            st_config_r, st_config_w:     xfer.reg_addr = config_addr;
            st_designcap:                 xfer.reg_addr = designcap_addr;
            st_modelcfg_w, st_modelcfg_r: xfer.reg_addr = modelcfg_addr;
            st_fullcap:                   xfer.reg_addr = fullcaprep_addr;
            st_repsoc:                    xfer.reg_addr = repsoc_addr;
            st_repcap:                    xfer.reg_addr = repcap_addr;
            st_age:                       xfer.reg_addr = age_addr;
            st_temp:                      xfer.reg_addr = temp_addr;
            default:                      xfer.reg_addr = status_addr;
        endcase
    end

    // ============================================================
    // result bank control
    always_comb begin
        case (state)
            st_repsoc: meas_sel = meas_repsoc;
            st_repcap: meas_sel = meas_repcap;
            st_age:    meas_sel = meas_age;
            st_temp:   meas_sel = meas_temp;
            default:   meas_sel = meas_fullcap;
        endcase
    end

    assign capture = xfer.finish && (state inside {[st_fullcap:st_temp]});
    assign publish = (state == st_publish);

    a_finish_in_xfer: assert property (@(posedge clk) disable iff (!rst_n)
        xfer.finish |-> is_xfer(state));
    a_engine_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !is_xfer(state) |-> !xfer.busy);

endmodule

`default_nettype wire

//--- hdl/gauge_xfer_if.sv
// one 16-bit register transfer between the sequencer and the transfer engine
// the sequencer pulses start, the engine answers with finish and rd_word
`timescale 1ns/1ps
`default_nettype none

interface gauge_xfer_if import gauge_pkg::*; ();

    logic        start;     // one-cycle request
    xfer_op_t    op;
    gauge_addr_t reg_addr;
    gauge_word_t wr_word;   // sampled with start
    logic        busy;
    logic        finish;    // one-cycle completion
    gauge_word_t rd_word;   // valid from finish on

    modport seq (
        output start, op, reg_addr, wr_word,
        input  busy, finish, rd_word
    );

    modport xfer (
        input  start, op, reg_addr, wr_word,
        output busy, finish, rd_word
    );

endinterface

`default_nettype wire

//--- hdl/result_bank.sv
// measurement result store
// working registers fill during a pass, outputs load together on publish
`timescale 1ns/1ps
`default_nettype none

module result_bank import gauge_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        capture,
    input  wire meas_sel_t   meas_sel,
    input  wire logic        publish,
    input  wire gauge_word_t rd_word,
    output gauge_word_t      fullcap,
    output gauge_word_t      repsoc,
    output gauge_word_t      repcap,
    output gauge_word_t      age,
    output gauge_word_t      thrmtemp
);

    gauge_word_t fullcap_w, repsoc_w, repcap_w, age_w, temp_w;

    always_ff @(posedge clk) begin
        if (capture) begin
            case (meas_sel)
                meas_fullcap: fullcap_w <= rd_word;
                meas_repsoc:  repsoc_w  <= rd_word;
                meas_repcap:  repcap_w  <= rd_word;
                meas_age:     age_w     <= rd_word;
                meas_temp:    temp_w    <= rd_word;
                default: ;
            endcase
        end
    end

    // outputs always show one complete pass
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fullcap  <= '0;
            repsoc   <= '0;
            repcap   <= '0;
            age      <= '0;
            thrmtemp <= '0;
        end else if (publish) begin
            fullcap  <= fullcap_w;
            repsoc   <= repsoc_w;
            repcap   <= repcap_w;
            age      <= age_w;
            thrmtemp <= temp_w;
        end
    end

endmodule

`default_nettype wire

//--- hdl/word_transfer.sv
// turns one 16-bit register transfer into byte strobes for the I2C controller
// low byte first in both directions, enable level held from ready to done
`timescale 1ns/1ps
`default_nettype none

module word_transfer import gauge_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    gauge_xfer_if.xfer       xfer,
    output gauge_addr_t      word_addr,
    output logic             wen,
    output logic             ren,
    output logic [7:0]       wdata,
    input  wire logic        wvalid,
    input  wire logic        rvalid,
    input  wire logic [7:0]  rdata,
    input  wire logic        ready,
    input  wire logic        done
);

    xfer_op_t    op_q;
    gauge_word_t wr_q;
    logic        hi_sel;  // low byte sent, high byte on wdata

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xfer.busy   <= 1'b0;
            xfer.finish <= 1'b0;
            wen         <= 1'b0;
            ren         <= 1'b0;
            hi_sel      <= 1'b0;
            op_q        <= op_read;
            wr_q        <= '0;
            word_addr   <= '0;
        end else begin
            xfer.finish <= xfer.busy && done;  // one clock after done
            if (xfer.start) begin
                xfer.busy <= 1'b1;
                hi_sel    <= 1'b0;
                op_q      <= xfer.op;
                wr_q      <= xfer.wr_word;
                word_addr <= xfer.reg_addr;
            end else if (xfer.busy && done) begin
                xfer.busy <= 1'b0;
                wen       <= 1'b0;
                ren       <= 1'b0;
            end else if (xfer.busy && !wen && !ren && ready) begin
                wen <= (op_q == op_write);
                ren <= (op_q == op_read);
            end
            if (wen && wvalid)
                hi_sel <= 1'b1;
        end
    end

    // read bytes shift in from the top, low byte arrives first
    always_ff @(posedge clk) begin
        if (ren && rvalid)
            xfer.rd_word <= {rdata, xfer.rd_word[15:8]};
    end

    assign wdata = hi_sel ? wr_q[15:8] : wr_q[7:0];

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        xfer.start |-> !xfer.busy);
    a_done_in_xfer: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (wen || ren));

endmodule

`default_nettype wire

//--- project.f
hdl/gauge_pkg.sv
hdl/gauge_xfer_if.sv
hdl/gauge_sequencer.sv
hdl/word_transfer.sv
hdl/result_bank.sv
hdl/fuel_gauge_top.sv
bench/i2c_gauge_model.sv
bench/tb_fuel_gauge.sv
